// File: cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Data, address and instruction width
`define WORD_SIZE 16

// Architectural registers
`define NUM_REGS 4

// First fetch address after reset
`define RESET_PC 16'h0000

`endif

// File: cpu_pkg.sv
`include "cpu_params.svh"

package cpu_pkg;

	typedef logic [`WORD_SIZE-1:0] word_t;
	typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

	// Opcode field, bits 15:12
	typedef enum logic [3:0] {
		OP_BNE   = 4'd0,
		OP_BEQ   = 4'd1,
		OP_BGZ   = 4'd2,
		OP_BLZ   = 4'd3,
		OP_ADI   = 4'd4,
		OP_ORI   = 4'd5,
		OP_LHI   = 4'd6,
		OP_LWD   = 4'd7,
		OP_SWD   = 4'd8,
		OP_JMP   = 4'd9,
		OP_JAL   = 4'd10,
		OP_RTYPE = 4'd15
	} opcode_t;

	// Function field of opcode 15
	typedef enum logic [5:0] {
		FN_ADD = 6'd0,
		FN_SUB = 6'd1,
		FN_AND = 6'd2,
		FN_ORR = 6'd3,
		FN_NOT = 6'd4,
		FN_TCP = 6'd5,
		FN_SHL = 6'd6,
		FN_SHR = 6'd7,
		FN_JPR = 6'd25,
		FN_JRL = 6'd26,
		FN_WWD = 6'd28,
		FN_HLT = 6'd29
	} func_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_NOT,
		ALU_TCP,
		ALU_SHL,
		ALU_SHR,
		ALU_ORZ,
		ALU_LHI,
		ALU_PASS_B
	} alu_op_t;

	typedef enum logic [2:0] {
		S_FETCH,
		S_DECODE,
		S_EXECUTE,
		S_MEMORY,
		S_WRITEBACK,
		S_HALTED
	} cpu_state_t;

	typedef enum logic [1:0] {SRC_B_REG, SRC_B_IMM, SRC_B_ONE} alu_src_b_t;
	typedef enum logic [1:0] {PC_SEL_ALU, PC_SEL_JUMP, PC_SEL_REG} pc_sel_t;
	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC} wb_sel_t;
	typedef enum logic [1:0] {DEST_RT, DEST_RD, DEST_R2} wb_dest_t;

	typedef struct packed {
		logic  psel;
		logic  penable;
		logic  pwrite;
		word_t paddr;
		word_t pwdata;
	} apb_req_t;

	typedef struct packed {
		word_t prdata;
		logic  pready;
	} apb_rsp_t;

	typedef struct packed {
		logic       ir_write;
		logic       operand_latch;
		logic       alu_src_pc;
		alu_src_b_t alu_src_b;
		alu_op_t    alu_op;
		logic       alu_latch;
		logic       pc_write;
		logic       pc_cond_write;
		pc_sel_t    pc_sel;
		logic       mem_req;
		logic       mem_write;
		logic       mem_from_alu;
		logic       reg_write;
		wb_sel_t    wb_sel;
		wb_dest_t   wb_dest;
		logic       wwd_write;
	} ctrl_t;

endpackage

// File: apb_mem_port.sv
module apb_mem_port (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              mem_req,
	input  logic              mem_write,
	input  cpu_pkg::word_t    addr,
	input  cpu_pkg::word_t    wdata,
	output cpu_pkg::word_t    rdata,
	output logic              mem_done,
	output cpu_pkg::apb_req_t apb_req,
	input  cpu_pkg::apb_rsp_t apb_rsp
);
	import cpu_pkg::*;

	typedef enum logic [1:0] {PORT_IDLE, PORT_SETUP, PORT_ACCESS} port_state_t;

	port_state_t state;
	word_t addr_q;
	word_t wdata_q;
	logic write_q;
	word_t rdata_q;

	assign mem_done = (state == PORT_ACCESS) && apb_rsp.pready;

	// Read data passes through on completion and is held afterwards
	assign rdata = mem_done ? apb_rsp.prdata : rdata_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= PORT_IDLE;
		end else begin
			case (state)
				PORT_IDLE:   if (mem_req) state <= PORT_SETUP;
				PORT_SETUP:  state <= PORT_ACCESS;
				// Back-to-back transfer when the next request is already waiting
				PORT_ACCESS: if (apb_rsp.pready) state <= mem_req ? PORT_SETUP : PORT_IDLE;
				default:     state <= PORT_IDLE;
			endcase
		end
	end

	// Request captured at the end of setup and held through access
	always_ff @(posedge clk) begin
		if (state == PORT_SETUP) begin
			addr_q  <= addr;
			wdata_q <= wdata;
			write_q <= mem_write;
		end
		if (mem_done) begin
			rdata_q <= apb_rsp.prdata;
		end
	end

	always_comb begin
		apb_req.psel    = (state != PORT_IDLE);
		apb_req.penable = (state == PORT_ACCESS);
		apb_req.paddr   = (state == PORT_ACCESS) ? addr_q : addr;
		apb_req.pwrite  = (state == PORT_ACCESS) ? write_q : mem_write;
		apb_req.pwdata  = (state == PORT_ACCESS) ? wdata_q : wdata;
	end

	assert property (@(posedge clk) disable iff (!arst_n)
		(apb_req.penable && !apb_rsp.pready) |=>
			($stable(apb_req.paddr) && $stable(apb_req.pwrite)));

	assert property (@(posedge clk) disable iff (!arst_n)
		apb_req.penable |-> apb_req.psel);

endmodule

// File: register_file.sv
`include "cpu_params.svh"

module register_file (
	input  logic              clk,
	input  logic              arst_n,
	input  cpu_pkg::reg_idx_t read1,
	input  cpu_pkg::reg_idx_t read2,
	input  cpu_pkg::reg_idx_t write_idx,
	input  logic              write_en,
	input  cpu_pkg::word_t    write_data,
	output cpu_pkg::word_t    read_out1,
	output cpu_pkg::word_t    read_out2
);
	import cpu_pkg::*;

	word_t regs [`NUM_REGS];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en) begin
			regs[write_idx] <= write_data;
		end
	end

	assign read_out1 = regs[read1];
	assign read_out2 = regs[read2];

endmodule

// File: alu.sv
module alu (
	input  cpu_pkg::word_t   a,
	input  cpu_pkg::word_t   b,
	input  cpu_pkg::alu_op_t op,
	input  cpu_pkg::opcode_t branch_op,
	output cpu_pkg::word_t   result,
	output logic             bcond
);
	import cpu_pkg::*;

	always_comb begin
		case (op)
			ALU_ADD:    result = a + b;
			ALU_SUB:    result = a - b;
			ALU_AND:    result = a & b;
			ALU_OR:     result = a | b;
			ALU_NOT:    result = ~a;
			ALU_TCP:    result = ~a + 1'b1;
			ALU_SHL:    result = a << 1;
			// Arithmetic shift keeps the sign bit
			ALU_SHR:    result = {a[15], a[15:1]};
			ALU_ORZ:    result = a | {8'h00, b[7:0]};
			ALU_LHI:    result = {b[7:0], 8'h00};
			ALU_PASS_B: result = b;
			default:    result = b;
		endcase
	end

	// Signed tests for BGZ and BLZ
	always_comb begin
		case (branch_op)
			OP_BNE:  bcond = (a != b);
			OP_BEQ:  bcond = (a == b);
			OP_BGZ:  bcond = !a[15] && (a != '0);
			OP_BLZ:  bcond = a[15];
			default: bcond = 1'b0;
		endcase
	end

endmodule

// File: decode_stage.sv
module decode_stage (
	input  logic           clk,
	input  logic           arst_n,
	input  cpu_pkg::ctrl_t ctrl,
	input  cpu_pkg::word_t mem_rdata,
	input  cpu_pkg::word_t alu_out,
	input  cpu_pkg::word_t pc,
	output cpu_pkg::word_t inst,
	output cpu_pkg::word_t rs_val,
	output cpu_pkg::word_t rt_val,
	output cpu_pkg::word_t imm_ext
);
	import cpu_pkg::*;

	opcode_t opcode;
	word_t read_rs;
	word_t read_rt;
	word_t wb_data;
	reg_idx_t wb_idx;

	assign opcode = opcode_t'(inst[15:12]);

	always_ff @(posedge clk) begin
		if (ctrl.ir_write) begin
			inst <= mem_rdata;
		end
		if (ctrl.operand_latch) begin
			rs_val <= read_rs;
			rt_val <= read_rt;
		end
	end

	// ORI and LHI take the byte as is
	always_comb begin
		case (opcode)
			OP_ORI, OP_LHI: imm_ext = {8'h00, inst[7:0]};
			default:        imm_ext = {{8{inst[7]}}, inst[7:0]};
		endcase
	end

	always_comb begin
		case (ctrl.wb_dest)
			DEST_RT: wb_idx = inst[9:8];
			DEST_R2: wb_idx = 2'd2;
			default: wb_idx = inst[7:6];
		endcase
		case (ctrl.wb_sel)
			WB_MEM:  wb_data = mem_rdata;
			// Return address, PC was advanced in decode
			WB_PC:   wb_data = pc;
			default: wb_data = alu_out;
		endcase
	end

	register_file u_regs (
		.clk        (clk),
		.arst_n     (arst_n),
		.read1      (inst[11:10]),
		.read2      (inst[9:8]),
		.write_idx  (wb_idx),
		.write_en   (ctrl.reg_write),
		.write_data (wb_data),
		.read_out1  (read_rs),
		.read_out2  (read_rt)
	);

endmodule

// File: execute_stage.sv
`include "cpu_params.svh"

module execute_stage (
	input  logic           clk,
	input  logic           arst_n,
	input  cpu_pkg::ctrl_t ctrl,
	input  cpu_pkg::word_t inst,
	input  cpu_pkg::word_t rs_val,
	input  cpu_pkg::word_t rt_val,
	input  cpu_pkg::word_t imm_ext,
	output cpu_pkg::word_t pc,
	output cpu_pkg::word_t alu_out,
	output cpu_pkg::word_t output_port,
	output logic           bcond
);
	import cpu_pkg::*;

	opcode_t opcode;
	word_t alu_a;
	word_t alu_b;
	word_t alu_result;
	word_t next_pc;

	assign opcode = opcode_t'(inst[15:12]);
	assign alu_a = ctrl.alu_src_pc ? pc : rs_val;

	always_comb begin
		case (ctrl.alu_src_b)
			SRC_B_IMM: alu_b = imm_ext;
			SRC_B_ONE: alu_b = word_t'(1);
			default:   alu_b = rt_val;
		endcase
		case (ctrl.pc_sel)
			PC_SEL_JUMP: next_pc = {pc[15:12], inst[11:0]};
			PC_SEL_REG:  next_pc = rs_val;
			default:     next_pc = alu_result;
		endcase
	end

	// Main datapath, also forms PC+1 and branch targets
	alu u_alu (
		.a         (alu_a),
		.b         (alu_b),
		.op        (ctrl.alu_op),
		.branch_op (opcode),
		.result    (alu_result),
		.bcond     ()
	);

	// Compares rs and rt while the main ALU adds the offset
	alu u_branch_cmp (
		.a         (rs_val),
		.b         (rt_val),
		.op        (ALU_SUB),
		.branch_op (opcode),
		.result    (),
		.bcond     (bcond)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc          <= `RESET_PC;
			output_port <= '0;
		end else begin
			if (ctrl.pc_write || (ctrl.pc_cond_write && bcond)) begin
				pc <= next_pc;
			end
			if (ctrl.wwd_write) begin
				output_port <= rs_val;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.alu_latch) begin
			alu_out <= alu_result;
		end
	end

endmodule

// File: control_fsm.sv
module control_fsm (
	input  logic           clk,
	input  logic           arst_n,
	input  cpu_pkg::word_t inst,
	input  logic           mem_done,
	input  logic           bcond,
	output cpu_pkg::ctrl_t ctrl,
	output cpu_pkg::word_t num_inst,
	output logic           is_halted
);
	import cpu_pkg::*;

	cpu_state_t state;
	cpu_state_t next_state;
	opcode_t opcode;
	func_t func;
	logic is_rtype;
	logic is_mem;
	logic writes_back;
	logic inst_done;

	assign opcode = opcode_t'(inst[15:12]);
	assign func = func_t'(inst[5:0]);
	assign is_rtype = (opcode == OP_RTYPE);
	assign is_mem = opcode inside {OP_LWD, OP_SWD};
	assign writes_back = (opcode inside {OP_ADI, OP_ORI, OP_LHI}) || (is_rtype &&
		(func inside {FN_ADD, FN_SUB, FN_AND, FN_ORR, FN_NOT, FN_TCP, FN_SHL, FN_SHR}));

	always_comb begin
		next_state = state;
		case (state)
			S_FETCH:     if (mem_done) next_state = S_DECODE;
			S_DECODE:    next_state = (is_rtype && func == FN_HLT) ? S_HALTED : S_EXECUTE;
			S_EXECUTE: begin
				if (is_mem) begin
					next_state = S_MEMORY;
				end else if (writes_back) begin
					next_state = S_WRITEBACK;
				end else begin
					next_state = S_FETCH;
				end
			end
			S_MEMORY: begin
				if (mem_done) begin
					next_state = (opcode == OP_LWD) ? S_WRITEBACK : S_FETCH;
				end
			end
			S_WRITEBACK: next_state = S_FETCH;
			default:     next_state = S_HALTED;
		endcase
	end

	always_comb begin
		ctrl = '0;
		ctrl.alu_src_b = SRC_B_REG;
		ctrl.alu_op = ALU_PASS_B;
		ctrl.pc_sel = PC_SEL_ALU;
		ctrl.wb_sel = WB_ALU;
		ctrl.wb_dest = DEST_RD;
		// Requested one cycle ahead so the APB setup phase opens the access
		ctrl.mem_req = (next_state == S_FETCH) || (next_state == S_MEMORY);
		case (state)
			S_FETCH: ctrl.ir_write = mem_done;
			S_DECODE: begin
				ctrl.operand_latch = 1'b1;
				ctrl.alu_src_pc = 1'b1;
				ctrl.alu_src_b = SRC_B_ONE;
				ctrl.alu_op = ALU_ADD;
				ctrl.pc_write = 1'b1;
			end
			S_EXECUTE: begin
				ctrl.alu_latch = writes_back || is_mem;
				case (opcode)
					OP_RTYPE: begin
						case (func)
							FN_ADD: ctrl.alu_op = ALU_ADD;
							FN_SUB: ctrl.alu_op = ALU_SUB;
							FN_AND: ctrl.alu_op = ALU_AND;
							FN_ORR: ctrl.alu_op = ALU_OR;
							FN_NOT: ctrl.alu_op = ALU_NOT;
							FN_TCP: ctrl.alu_op = ALU_TCP;
							FN_SHL: ctrl.alu_op = ALU_SHL;
							FN_SHR: ctrl.alu_op = ALU_SHR;
							FN_WWD: ctrl.wwd_write = 1'b1;
							FN_JPR, FN_JRL: begin
								ctrl.pc_write = 1'b1;
								ctrl.pc_sel = PC_SEL_REG;
								ctrl.reg_write = (func == FN_JRL);
								ctrl.wb_sel = WB_PC;
								ctrl.wb_dest = DEST_R2;
							end
							default: ;
						endcase
					end
					OP_ADI, OP_LWD, OP_SWD: begin
						ctrl.alu_src_b = SRC_B_IMM;
						ctrl.alu_op = ALU_ADD;
					end
					OP_ORI: begin
						ctrl.alu_src_b = SRC_B_IMM;
						ctrl.alu_op = ALU_ORZ;
					end
					OP_LHI: begin
						ctrl.alu_src_b = SRC_B_IMM;
						ctrl.alu_op = ALU_LHI;
					end
					OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ: begin
						ctrl.alu_src_pc = 1'b1;
						ctrl.alu_src_b = SRC_B_IMM;
						ctrl.alu_op = ALU_ADD;
						ctrl.pc_cond_write = 1'b1;
					end
					// Return address written while PC still holds PC+1
					OP_JMP, OP_JAL: begin
						ctrl.pc_write = 1'b1;
						ctrl.pc_sel = PC_SEL_JUMP;
						ctrl.reg_write = (opcode == OP_JAL);
						ctrl.wb_sel = WB_PC;
						ctrl.wb_dest = DEST_R2;
					end
					default: ;
				endcase
			end
			S_MEMORY: begin
				ctrl.mem_from_alu = 1'b1;
				ctrl.mem_write = (opcode == OP_SWD);
			end
			S_WRITEBACK: begin
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel = (opcode == OP_LWD) ? WB_MEM : WB_ALU;
				ctrl.wb_dest = is_rtype ? DEST_RD : DEST_RT;
			end
			default: ;
		endcase
	end

	// Last cycle of an instruction including HLT
	assign inst_done = ((state != S_FETCH) && (next_state == S_FETCH)) ||
		((state == S_DECODE) && (next_state == S_HALTED));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= S_FETCH;
			num_inst <= '0;
		end else begin
			state <= next_state;
			if (inst_done) begin
				num_inst <= num_inst + 1'b1;
			end
		end
	end

	assign is_halted = (state == S_HALTED);

	assert property (@(posedge clk) disable iff (!arst_n)
		ctrl.ir_write |-> (state == S_FETCH && mem_done));

endmodule

// File: cpu.sv
module cpu (
	input  logic              clk,
	input  logic              arst_n,
	output cpu_pkg::apb_req_t apb_req,
	input  cpu_pkg::apb_rsp_t apb_rsp,
	output cpu_pkg::word_t    num_inst,
	output cpu_pkg::word_t    output_port,
	output logic              is_halted
);
	import cpu_pkg::*;

	ctrl_t ctrl;
	word_t inst;
	word_t rs_val;
	word_t rt_val;
	word_t imm_ext;
	word_t pc;
	word_t alu_out;
	word_t mem_rdata;
	word_t mem_addr;
	logic mem_done;
	logic bcond;

	// Data accesses use the computed address, fetches use PC
	assign mem_addr = ctrl.mem_from_alu ? alu_out : pc;

	control_fsm u_ctrl (
		.clk       (clk),
		.arst_n    (arst_n),
		.inst      (inst),
		.mem_done  (mem_done),
		.bcond     (bcond),
		.ctrl      (ctrl),
		.num_inst  (num_inst),
		.is_halted (is_halted)
	);

	apb_mem_port u_mem (
		.clk       (clk),
		.arst_n    (arst_n),
		.mem_req   (ctrl.mem_req),
		.mem_write (ctrl.mem_write),
		.addr      (mem_addr),
		.wdata     (rt_val),
		.rdata     (mem_rdata),
		.mem_done  (mem_done),
		.apb_req   (apb_req),
		.apb_rsp   (apb_rsp)
	);

	decode_stage u_decode (
		.clk       (clk),
		.arst_n    (arst_n),
		.ctrl      (ctrl),
		.mem_rdata (mem_rdata),
		.alu_out   (alu_out),
		.pc        (pc),
		.inst      (inst),
		.rs_val    (rs_val),
		.rt_val    (rt_val),
		.imm_ext   (imm_ext)
	);

	execute_stage u_execute (
		.clk         (clk),
		.arst_n      (arst_n),
		.ctrl        (ctrl),
		.inst        (inst),
		.rs_val      (rs_val),
		.rt_val      (rt_val),
		.imm_ext     (imm_ext),
		.pc          (pc),
		.alu_out     (alu_out),
		.output_port (output_port),
		.bcond       (bcond)
	);

endmodule

// File: tb_cpu.sv
module tb_cpu;
	import cpu_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int DRIVE_DELAY = 1;
	localparam int RESET_CYCLES = 5;
	localparam int FILE_WORDS = 512;
	localparam int MEM_WORDS = 256;
	localparam int TRAILER_BASE = 256;
	localparam int NUM_GROUPS = 4;
	localparam int MAX_WAIT = 3;
	localparam int HALT_TIMEOUT = 5000;
	localparam int HALT_WATCH = 20;
	localparam logic [31:0] RAND_SEED = 32'ha79d455d;

	localparam int T_ARITH = 0;
	localparam int T_MEM = 1;
	localparam int T_BRANCH = 2;
	localparam int T_JUMP = 3;
	localparam int T_HALT = 4;
	localparam int T_APB = 5;
	localparam int NUM_TESTS = 6;

	logic clk;
	logic arst_n;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	word_t num_inst;
	word_t output_port;
	logic is_halted;

	word_t file_words [FILE_WORDS];
	word_t mem [MEM_WORDS];
	word_t exp_out [$];
	int exp_group [$];
	word_t store_addr;
	word_t store_val;
	word_t exp_count;
	int test_errors [NUM_TESTS];
	string test_names [NUM_TESTS];
	int checks_run;
	int out_idx;
	word_t last_out;
	int wait_left;
	logic stalled_q;
	apb_req_t held_req;
	logic halt_seen;
	int late_transfers;

	cpu u_cpu (
		.clk         (clk),
		.arst_n      (arst_n),
		.apb_req     (apb_req),
		.apb_rsp     (apb_rsp),
		.num_inst    (num_inst),
		.output_port (output_port),
		.is_halted   (is_halted)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic compare_word(input int test_idx, input word_t actual, input word_t expected,
			input string what);
		checks_run++;
		if (actual !== expected) begin
			test_errors[test_idx]++;
			$display("Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic print_test_line(input int idx);
		$display("[%0d] %s: %s, %0d errors", idx, test_names[idx],
			(test_errors[idx] == 0) ? "PASS" : "FAIL", test_errors[idx]);
	endtask

	// Image words first and then per group an output count with its values
	task automatic load_image();
		int pos;
		int count;
		for (int i = 0; i < FILE_WORDS; i++) begin
			file_words[i] = word_t'(i * 257) ^ 16'hFF00;
		end
		$readmemh("cpu_input.txt", file_words);
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = file_words[i];
		end
		pos = TRAILER_BASE;
		for (int g = 0; g < NUM_GROUPS; g++) begin
			count = int'(file_words[pos]);
			pos++;
			for (int j = 0; j < count && pos < FILE_WORDS; j++) begin
				exp_out.push_back(file_words[pos]);
				exp_group.push_back(g);
				pos++;
			end
		end
		store_addr = file_words[pos];
		store_val = file_words[pos + 1];
		exp_count = file_words[pos + 2];
	endtask

	task automatic wait_for_halt(output logic halted);
		int cycles;
		cycles = 0;
		while (!is_halted && cycles < HALT_TIMEOUT) begin
			@(posedge clk);
			#DRIVE_DELAY;
			cycles++;
		end
		halted = is_halted;
	endtask

	task automatic finish_program_tests();
		for (int i = out_idx; i < exp_out.size(); i++) begin
			test_errors[exp_group[i]]++;
			$display("Missing output_port value %h, expected as entry %0d", exp_out[i], i);
		end
		compare_word(T_MEM, mem[store_addr[7:0]], store_val, "stored word in memory");
		for (int t = T_ARITH; t <= T_JUMP; t++) begin
			print_test_line(t);
		end
	endtask

	task automatic watch_after_halt();
		int low_cycles;
		low_cycles = 0;
		for (int i = 0; i < HALT_WATCH; i++) begin
			@(posedge clk);
			#DRIVE_DELAY;
			if (!is_halted) begin
				low_cycles++;
			end
		end
		compare_word(T_HALT, word_t'(low_cycles), 16'd0, "cycles with is_halted low after HLT");
		compare_word(T_HALT, word_t'(late_transfers), 16'd0, "APB transfers started after HLT");
		compare_word(T_HALT, num_inst, exp_count, "num_inst");
	endtask

	// APB memory with random wait states and per-cycle protocol checks
	always @(posedge clk) begin
		#DRIVE_DELAY;
		if (arst_n) begin
			if (apb_req.penable && !apb_req.psel) begin
				test_errors[T_APB]++;
				$display("APB penable is high without psel at time %0t", $time);
			end
			if (apb_req.psel && apb_req.paddr[15:8] != 8'h00) begin
				test_errors[T_APB]++;
				$display("APB address %h is outside the memory at time %0t", apb_req.paddr, $time);
			end
			if (stalled_q && apb_req.penable) begin
				compare_word(T_APB, apb_req.paddr, held_req.paddr, "paddr in wait state");
				compare_word(T_APB, word_t'(apb_req.pwrite), word_t'(held_req.pwrite),
					"pwrite in wait state");
				if (held_req.pwrite) begin
					compare_word(T_APB, apb_req.pwdata, held_req.pwdata, "pwdata in wait state");
				end
			end
			if (apb_req.psel && !apb_req.penable) begin
				wait_left = int'($urandom % (MAX_WAIT + 1));
				if (halt_seen) begin
					late_transfers++;
				end
				apb_rsp.pready = 1'b0;
			end else if (apb_req.psel) begin
				if (wait_left > 0) begin
					wait_left--;
					apb_rsp.pready = 1'b0;
				end else begin
					apb_rsp.pready = 1'b1;
					if (apb_req.pwrite) begin
						mem[apb_req.paddr[7:0]] = apb_req.pwdata;
					end else begin
						apb_rsp.prdata = mem[apb_req.paddr[7:0]];
					end
				end
			end else begin
				apb_rsp.pready = 1'b0;
			end
			stalled_q = apb_req.penable && !apb_rsp.pready;
			held_req = apb_req;
		end
	end

	// Every new output_port value is the next WWD result
	always @(posedge clk) begin
		#DRIVE_DELAY;
		if (arst_n && output_port != last_out) begin
			if (out_idx < exp_out.size()) begin
				compare_word(exp_group[out_idx], output_port, exp_out[out_idx], "output_port");
			end else begin
				test_errors[T_JUMP]++;
				$display("Unexpected extra output_port value %h at time %0t", output_port, $time);
			end
			last_out = output_port;
			out_idx++;
		end
	end

	initial begin
		logic halted;
		int total;
		int clean;
		arst_n = 1'b0;
		apb_rsp = '0;
		held_req = '0;
		stalled_q = 1'b0;
		wait_left = 0;
		halt_seen = 1'b0;
		late_transfers = 0;
		checks_run = 0;
		out_idx = 0;
		last_out = '0;
		for (int i = 0; i < NUM_TESTS; i++) begin
			test_errors[i] = 0;
		end
		test_names[T_ARITH] = "arithmetic and logic";
		test_names[T_MEM] = "load and store";
		test_names[T_BRANCH] = "branches";
		test_names[T_JUMP] = "jumps";
		test_names[T_HALT] = "halt and count";
		test_names[T_APB] = "apb protocol";
		void'($urandom(RAND_SEED));
		load_image();

		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		arst_n = 1'b1;

		wait_for_halt(halted);
		if (!halted) begin
			$display("Timeout: is_halted did not rise within %0d cycles", HALT_TIMEOUT);
			$display("Test failed");
			$finish;
		end else begin
			halt_seen = 1'b1;
			finish_program_tests();
			watch_after_halt();
			print_test_line(T_HALT);
			print_test_line(T_APB);
			total = 0;
			clean = 0;
			for (int i = 0; i < NUM_TESTS; i++) begin
				total += test_errors[i];
				if (test_errors[i] == 0) begin
					clean++;
				end
			end
			$display("Summary: %0d checks, %0d errors, %0d of %0d tests clean",
				checks_run, total, clean, NUM_TESTS);
			if (total == 0) begin
				$display("Test completed successfully");
			end else begin
				$display("Test failed");
			end
			$finish;
		end
	end

endmodule

// File: cpu_input.txt
// Memory image at 000-0FF, one 16-bit hex word per entry
// Trailer at 100: per group an output count and WWD values, then store addr, store data, num_inst
@000
// LHI ORI ADI ADD SUB AND ORR NOT TCP SHL SHR, each followed by WWD
6012 F01C 5084 F01C 41FE F41C F180 F81C
F1C1 FC1C F182 F81C F1C3 FC1C F084 F81C
F0C5 FC1C F086 F81C F0C7 FC1C
// Store to 0080, load it back, then load the preset word at 0081
4D31 6000 5082 81FE 72FE F81C 73FF FC1C
// BNE taken and not taken, BEQ taken and not taken
0701 4040 4001 F01C 0601 4001 F01C
1601 4040 4001 F01C 1701 4001 F01C
// BGZ taken and not taken, BLZ taken and not taken
2401 4040 4001 F01C 2C01 4001 F01C
3C01 4040 4001 F01C 3401 4001 F01C
// JMP, JAL with WWD r2, JPR, JRL with WWD r2, HLT
903D 4040 4040 4001 F01C
A042 4040 4040 F81C
6100 5548 F419 4040 4040 4001 F01C
4506 F41A 4040 4040 F81C
F01D
@081
C3A5
@100
// Arithmetic outputs
000B 1200 1284 1282 2506 0002 1280 1286 ED7B ED7C 2508 0942
// Load and store outputs
0002 0973 C3A5
// Branch markers
0008 0083 0084 0085 0086 0087 0088 0089 008A
// Jump marker and return addresses
0004 008B 0040 008C 004C
// Store address, stored value, final instruction count
0080 0973 0044

// File: all.f
+incdir+.
cpu_pkg.sv
apb_mem_port.sv
register_file.sv
alu.sv
decode_stage.sv
execute_stage.sv
control_fsm.sv
cpu.sv
tb_cpu.sv

// File: run.sh
#!/bin/sh
# Build and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_cpu -o tb_cpu_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/tb_cpu_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -q "^Test completed successfully$"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
